/* Makefile */
# Verilator simulation of the LDPC encoder testbench

VERILATOR ?= verilator
TOP       ?= tb_ldpc_encoder
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+common
+incdir+sim
common/ldpc_pkg.sv
parity/circulant_row_sum.sv
parity/core_parity.sv
parity/ext_parity.sv
verilog/handshake_ctrl.sv
verilog/ldpc_encoder.sv
sim/tb_ldpc_encoder.sv

/* common/ldpc_macros.svh */
`ifndef LDPC_MACROS_SVH
`define LDPC_MACROS_SVH

// lifting size and base graph dimensions
`define LDPC_ZC          2
`define LDPC_KB          10
`define LDPC_CORE_ROWS   4
`define LDPC_EXT_ROWS    38
`define LDPC_EXT_COLS    (`LDPC_KB + `LDPC_CORE_ROWS)   // C1 then D columns

// widths
`define LDPC_CRC_BITS    16
`define LDPC_MSG_BITS    (`LDPC_KB * `LDPC_ZC)
`define LDPC_CW_BITS     100
`define LDPC_SHIFT_BITS  4

// base graph entry for an all-zero block
`define LDPC_NULL_SHIFT  4'hF

`endif

/* common/ldpc_pkg.sv */
`default_nettype none

`include "ldpc_macros.svh"

package ldpc_pkg;

    typedef logic [`LDPC_ZC-1:0]         block_t;
    typedef logic [`LDPC_SHIFT_BITS-1:0] shift_t;    // cyclic shift or null code
    typedef logic [`LDPC_MSG_BITS-1:0]   message_t;  // crc in 16:1, data bit in 0
    typedef logic [`LDPC_CW_BITS-1:0]    codeword_t;

    typedef enum logic [1:0] {
        IDLE,
        CORE,
        EXT,
        DONE
    } enc_state_e;

    // A part, one line per core row
    localparam shift_t a_shifts [`LDPC_CORE_ROWS][`LDPC_KB] = '{
        '{4'h1, 4'h1, 4'h0, 4'h0, 4'hF, 4'hF, 4'h1, 4'hF, 4'hF, 4'h1},
        '{4'h1, 4'hF, 4'hF, 4'h0, 4'h1, 4'h1, 4'h0, 4'h0, 4'h0, 4'h0},
        '{4'h1, 4'h0, 4'hF, 4'h0, 4'h0, 4'hF, 4'hF, 4'hF, 4'h0, 4'hF},
        '{4'hF, 4'h0, 4'h0, 4'hF, 4'h0, 4'h0, 4'h1, 4'h0, 4'h0, 4'h0}
    };

    // extension rows, ten C1 entries on message blocks then four D entries on pa
    localparam shift_t ext_shifts [`LDPC_EXT_ROWS][`LDPC_EXT_COLS] = '{
        '{4'h1, 4'h0, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'h1, 4'hF, 4'hF},
        '{4'h1, 4'h1, 4'hF, 4'hF, 4'hF, 4'h0, 4'hF, 4'h1, 4'hF, 4'hF,  4'hF, 4'h1, 4'hF, 4'hF},
        '{4'h1, 4'hF, 4'hF, 4'hF, 4'hF, 4'h0, 4'hF, 4'h1, 4'hF, 4'h0,  4'hF, 4'h0, 4'hF, 4'hF},
        '{4'hF, 4'h1, 4'hF, 4'hF, 4'hF, 4'h1, 4'hF, 4'h0, 4'hF, 4'hF,  4'hF, 4'h1, 4'hF, 4'h0},
        '{4'h0, 4'h0, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'hF, 4'h0, 4'hF},
        '{4'hF, 4'h1, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'h1, 4'hF,  4'h1, 4'h1, 4'hF, 4'hF},
        '{4'h1, 4'h1, 4'hF, 4'hF, 4'hF, 4'hF, 4'h0, 4'h1, 4'hF, 4'hF,  4'hF, 4'hF, 4'hF, 4'hF},
        '{4'h1, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'h0, 4'hF, 4'h0,  4'hF, 4'hF, 4'hF, 4'h0},
        '{4'hF, 4'h1, 4'hF, 4'h1, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'h0, 4'hF, 4'hF},
        '{4'h1, 4'h0, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'h0, 4'hF,  4'hF, 4'hF, 4'hF, 4'h0},
        '{4'hF, 4'h1, 4'hF, 4'hF, 4'hF, 4'hF, 4'h1, 4'hF, 4'hF, 4'hF,  4'hF, 4'h1, 4'hF, 4'h0},
        '{4'h1, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,  4'h1, 4'h1, 4'hF, 4'hF},
        '{4'hF, 4'h1, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'h0,  4'hF, 4'h0, 4'h0, 4'hF},
        '{4'hF, 4'h0, 4'hF, 4'hF, 4'hF, 4'h0, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'h0, 4'h0, 4'hF},
        '{4'h0, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'h0, 4'h0, 4'hF, 4'hF,  4'hF, 4'hF, 4'hF, 4'hF},
        '{4'h1, 4'h0, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,  4'h1, 4'hF, 4'hF, 4'hF},
        '{4'hF, 4'h0, 4'hF, 4'hF, 4'h1, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'h1, 4'hF, 4'hF},
        '{4'h0, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'h0, 4'hF,  4'hF, 4'hF, 4'hF, 4'h0},
        '{4'hF, 4'h0, 4'h1, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'hF, 4'hF, 4'hF},
        '{4'h1, 4'hF, 4'hF, 4'h1, 4'hF, 4'h0, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'hF, 4'hF, 4'hF},
        '{4'hF, 4'h0, 4'h1, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'h0,  4'hF, 4'hF, 4'hF, 4'hF},
        '{4'h0, 4'hF, 4'hF, 4'hF, 4'hF, 4'h0, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'hF, 4'hF, 4'hF},
        '{4'hF, 4'hF, 4'h1, 4'hF, 4'hF, 4'hF, 4'hF, 4'h1, 4'hF, 4'hF,  4'hF, 4'hF, 4'h0, 4'h0},
        '{4'h0, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'h1, 4'hF, 4'hF, 4'hF,  4'hF, 4'hF, 4'hF, 4'hF},
        '{4'hF, 4'h0, 4'h1, 4'hF, 4'hF, 4'h1, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'hF, 4'hF, 4'hF},
        '{4'h0, 4'hF, 4'hF, 4'hF, 4'h0, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'hF, 4'hF, 4'hF},
        '{4'hF, 4'hF, 4'h1, 4'hF, 4'hF, 4'h0, 4'hF, 4'h1, 4'hF, 4'h0,  4'hF, 4'hF, 4'hF, 4'hF},
        '{4'hF, 4'h0, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'hF, 4'hF, 4'h1},
        '{4'h0, 4'hF, 4'hF, 4'hF, 4'hF, 4'h0, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'hF, 4'h0, 4'hF},
        '{4'hF, 4'hF, 4'h0, 4'hF, 4'hF, 4'hF, 4'hF, 4'h0, 4'hF, 4'hF,  4'h1, 4'hF, 4'hF, 4'hF},
        '{4'h1, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'hF, 4'h1, 4'h0},
        '{4'hF, 4'h1, 4'hF, 4'hF, 4'hF, 4'h0, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'h1, 4'hF, 4'hF},
        '{4'h0, 4'hF, 4'h0, 4'hF, 4'hF, 4'hF, 4'hF, 4'h0, 4'hF, 4'hF,  4'hF, 4'hF, 4'hF, 4'hF},
        '{4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,  4'h1, 4'hF, 4'hF, 4'h1},
        '{4'hF, 4'h1, 4'hF, 4'hF, 4'hF, 4'h0, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'h0, 4'hF, 4'hF},
        '{4'h1, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'h0, 4'hF, 4'hF,  4'hF, 4'hF, 4'h0, 4'hF},
        '{4'hF, 4'hF, 4'h0, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,  4'h1, 4'hF, 4'hF, 4'h0},
        '{4'hF, 4'h1, 4'hF, 4'hF, 4'hF, 4'h1, 4'hF, 4'hF, 4'hF, 4'hF,  4'hF, 4'h0, 4'hF, 4'hF}
    };

endpackage

`default_nettype wire

/* parity/circulant_row_sum.sv */
`timescale 1ns/1ns
`include "ldpc_macros.svh"
`default_nettype none

module circulant_row_sum #(
    parameter int NUM_COLS = `LDPC_KB
) (
    input  ldpc_pkg::block_t blocks [NUM_COLS],
    input  ldpc_pkg::shift_t shifts [NUM_COLS],
    output ldpc_pkg::block_t row_sum
);

    ldpc_pkg::block_t rotated [NUM_COLS];

    // cyclic shift of each column block
    always_comb begin
        for (int c = 0; c < NUM_COLS; c++) begin
            rotated[c] = '0;   // null entry stays zero
            if (shifts[c] != `LDPC_NULL_SHIFT) begin
                for (int m = 0; m < `LDPC_ZC; m++) begin
                    rotated[c][m] = blocks[c][(m + int'(shifts[c])) % `LDPC_ZC];
                end
            end
        end
    end

    // gf(2) accumulate across the row
    always_comb begin
        row_sum = '0;
        for (int c = 0; c < NUM_COLS; c++) begin
            row_sum = row_sum ^ rotated[c];
        end
    end

endmodule

`default_nettype wire

/* parity/core_parity.sv */
`timescale 1ns/1ns
`include "ldpc_macros.svh"
`default_nettype none

module core_parity (
    input  logic               CLK,
    input  logic               RST,
    input  ldpc_pkg::message_t message,
    input  logic               core_load,
    output ldpc_pkg::block_t   pa_blocks [`LDPC_CORE_ROWS]
);

    ldpc_pkg::block_t msg_blocks [`LDPC_KB];
    ldpc_pkg::block_t lambda [`LDPC_CORE_ROWS];
    ldpc_pkg::block_t lambda_sum;
    ldpc_pkg::block_t pa0_next;
    ldpc_pkg::block_t pa1_next;

    // split message into lifted blocks, block 0 in the low bits
    always_comb begin
        for (int b = 0; b < `LDPC_KB; b++) begin
            msg_blocks[b] = message[b*`LDPC_ZC +: `LDPC_ZC];
        end
    end

    genvar r;
    generate
        for (r = 0; r < `LDPC_CORE_ROWS; r++) begin : g_core_row
            circulant_row_sum #(
                .NUM_COLS (`LDPC_KB)
            ) u_row_sum (
                .blocks  (msg_blocks),
                .shifts  (ldpc_pkg::a_shifts[r]),
                .row_sum (lambda[r])
            );
        end
    endgenerate

    assign lambda_sum = lambda[0] ^ lambda[1] ^ lambda[2] ^ lambda[3];

    // pa0 is the lambda sum rotated by one
    assign pa0_next = {lambda_sum[`LDPC_ZC-2:0], lambda_sum[`LDPC_ZC-1]};
    assign pa1_next = pa0_next ^ lambda[0];

    always_ff @(posedge CLK) begin
        if (core_load) begin
            pa_blocks[0] <= pa0_next;
            pa_blocks[1] <= pa1_next;
            pa_blocks[2] <= pa1_next ^ lambda[1];   // kb=10 diagonal
            pa_blocks[3] <= pa0_next ^ lambda[3];
        end
    end

    // solved blocks feed the extension stage on the next cycle
    a_pa_known: assert property (@(posedge CLK) disable iff (!RST)
        core_load |=> !$isunknown({pa_blocks[0], pa_blocks[1], pa_blocks[2], pa_blocks[3]}));

endmodule

`default_nettype wire

/* parity/ext_parity.sv */
`timescale 1ns/1ns
`include "ldpc_macros.svh"
`default_nettype none

module ext_parity (
    input  logic                CLK,
    input  logic                RST,
    input  ldpc_pkg::message_t  message,
    input  ldpc_pkg::block_t    pa_blocks [`LDPC_CORE_ROWS],
    input  logic                ext_load,
    output ldpc_pkg::codeword_t codeword
);

    localparam int INFO_BITS = `LDPC_MSG_BITS - 2 * `LDPC_ZC;   // first two blocks punctured
    localparam int PC_BASE   = INFO_BITS + `LDPC_CORE_ROWS * `LDPC_ZC;

    ldpc_pkg::block_t    ext_cols [`LDPC_EXT_COLS];
    ldpc_pkg::block_t    pc [`LDPC_EXT_ROWS];
    ldpc_pkg::codeword_t cw_next;

    // message blocks, then core parity for the D columns
    always_comb begin
        for (int b = 0; b < `LDPC_KB; b++) begin
            ext_cols[b] = message[b*`LDPC_ZC +: `LDPC_ZC];
        end
        for (int p = 0; p < `LDPC_CORE_ROWS; p++) begin
            ext_cols[`LDPC_KB + p] = pa_blocks[p];
        end
    end

    genvar r;
    generate
        for (r = 0; r < `LDPC_EXT_ROWS; r++) begin : g_ext_row
            circulant_row_sum #(
                .NUM_COLS (`LDPC_EXT_COLS)
            ) u_row_sum (
                .blocks  (ext_cols),
                .shifts  (ldpc_pkg::ext_shifts[r]),
                .row_sum (pc[r])
            );
        end
    endgenerate

    // pc37..pc0, pa3..pa0, message 19:4 from msb down
    always_comb begin
        cw_next = '0;
        cw_next[INFO_BITS-1:0] = message[`LDPC_MSG_BITS-1 -: INFO_BITS];
        for (int p = 0; p < `LDPC_CORE_ROWS; p++) begin
            cw_next[INFO_BITS + p*`LDPC_ZC +: `LDPC_ZC] = pa_blocks[p];
        end
        for (int i = 0; i < `LDPC_EXT_ROWS; i++) begin
            cw_next[PC_BASE + i*`LDPC_ZC +: `LDPC_ZC] = pc[i];
        end
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            codeword <= '0;
        end else if (ext_load) begin
            codeword <= cw_next;
        end
    end

    // output held through DONE and back-pressure
    a_cw_hold: assert property (@(posedge CLK) disable iff (!RST)
        !ext_load |=> $stable(codeword));

endmodule

`default_nettype wire

/* sim/tb_ldpc_model.svh */
`ifndef TB_LDPC_MODEL_SVH
`define TB_LDPC_MODEL_SVH

`include "ldpc_macros.svh"

// crc in bits 16:1, data bit in bit 0, upper bits zero
function automatic ldpc_pkg::message_t model_message(
    input logic [`LDPC_CRC_BITS-1:0] crc,
    input logic                      data
);
    ldpc_pkg::message_t msg;
    msg = '0;
    msg[`LDPC_CRC_BITS:1] = crc;
    msg[0] = data;
    return msg;
endfunction

// output bit m takes source bit (m + shift) mod zc
function automatic ldpc_pkg::block_t model_rotate(
    input ldpc_pkg::block_t blk,
    input ldpc_pkg::shift_t shift
);
    ldpc_pkg::block_t res;
    res = '0;
    if (shift != `LDPC_NULL_SHIFT) begin
        for (int m = 0; m < `LDPC_ZC; m++) begin
            res[m] = blk[(m + int'(shift)) % `LDPC_ZC];
        end
    end
    return res;
endfunction

function automatic ldpc_pkg::codeword_t model_codeword(input ldpc_pkg::message_t msg);
    ldpc_pkg::block_t    cols [`LDPC_EXT_COLS];
    ldpc_pkg::block_t    lam [`LDPC_CORE_ROWS];
    ldpc_pkg::block_t    pa [`LDPC_CORE_ROWS];
    ldpc_pkg::block_t    pc [`LDPC_EXT_ROWS];
    ldpc_pkg::block_t    lam_sum;
    ldpc_pkg::codeword_t cw;
    int                  pos;
    for (int b = 0; b < `LDPC_KB; b++) begin
        cols[b] = msg[b*`LDPC_ZC +: `LDPC_ZC];
    end
    lam_sum = '0;
    for (int r = 0; r < `LDPC_CORE_ROWS; r++) begin
        lam[r] = '0;
        for (int c = 0; c < `LDPC_KB; c++) begin
            lam[r] ^= model_rotate(cols[c], ldpc_pkg::a_shifts[r][c]);
        end
        lam_sum ^= lam[r];
    end
    // double-diagonal solve
    pa[0] = model_rotate(lam_sum, 4'd1);
    pa[1] = pa[0] ^ lam[0];
    pa[2] = pa[1] ^ lam[1];
    pa[3] = pa[0] ^ lam[3];
    for (int p = 0; p < `LDPC_CORE_ROWS; p++) begin
        cols[`LDPC_KB + p] = pa[p];   // D columns
    end
    for (int r = 0; r < `LDPC_EXT_ROWS; r++) begin
        pc[r] = '0;
        for (int c = 0; c < `LDPC_EXT_COLS; c++) begin
            pc[r] ^= model_rotate(cols[c], ldpc_pkg::ext_shifts[r][c]);
        end
    end
    // fill from the msb down
    cw = '0;
    pos = `LDPC_CW_BITS;
    for (int i = `LDPC_EXT_ROWS - 1; i >= 0; i--) begin
        pos -= `LDPC_ZC;
        cw[pos +: `LDPC_ZC] = pc[i];
    end
    for (int p = `LDPC_CORE_ROWS - 1; p >= 0; p--) begin
        pos -= `LDPC_ZC;
        cw[pos +: `LDPC_ZC] = pa[p];
    end
    for (int k = `LDPC_MSG_BITS - 1; k >= 2 * `LDPC_ZC; k--) begin
        pos--;
        cw[pos] = msg[k];   // first two blocks punctured
    end
    return cw;
endfunction

task automatic check_codeword(
    input string               name,
    input ldpc_pkg::codeword_t got,
    input ldpc_pkg::codeword_t exp
);
    if (got !== exp) begin
        err_count++;
        $display("[FAIL] t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
endtask

task automatic check_ack(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        err_count++;
        $display("[FAIL] t=%0t %s: got %b expected %b", $time, name, got, exp);
    end
endtask

`endif

/* sim/tb_ldpc_encoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ldpc_macros.svh"

module tb_ldpc_encoder;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_FIXED       = 8;
    localparam int NUM_RANDOM      = 20;
    localparam int NUM_VECTORS     = NUM_FIXED + NUM_RANDOM;
    localparam int ACK_LATENCY     = 3;    // edges from req sample to ack
    localparam int ACK_LIMIT       = 10;
    localparam int WATCHDOG_CYCLES = NUM_VECTORS * 12 + 16;   // margin for reset

    typedef struct packed {
        logic [`LDPC_CRC_BITS-1:0] crc;
        logic                      data;
        logic                      rnd;   // replace crc and data with random values
    } stim_t;

    localparam stim_t FIXED_STIM [NUM_FIXED] = '{
        '{16'h0000, 1'b0, 1'b0},   // all-zero message
        '{16'hFFFF, 1'b1, 1'b0},
        '{16'h0001, 1'b0, 1'b0},
        '{16'h8000, 1'b0, 1'b0},
        '{16'h0000, 1'b1, 1'b0},   // data bit alone
        '{16'hA5A5, 1'b1, 1'b0},
        '{16'h1234, 1'b0, 1'b0},
        '{16'hDEAD, 1'b1, 1'b0}
    };

    logic                      CLK;
    logic                      RST;
    logic                      req;
    logic [`LDPC_CRC_BITS-1:0] crc_bits;
    logic                      data_bit;
    logic                      ack;
    ldpc_pkg::codeword_t       codeword;

    int    err_count;
    int    fail_tests;
    stim_t stim_table [NUM_VECTORS];

    `include "tb_ldpc_model.svh"

    ldpc_encoder u_ldpc_encoder (
        .CLK      (CLK),
        .RST      (RST),
        .req      (req),
        .crc_bits (crc_bits),
        .data_bit (data_bit),
        .ack      (ack),
        .codeword (codeword)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, handshake stalled", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic fill_table();
        for (int i = 0; i < NUM_VECTORS; i++) begin
            if (i < NUM_FIXED) begin
                stim_table[i] = FIXED_STIM[i];
            end else begin
                stim_table[i] = '{16'h0000, 1'b0, 1'b1};
            end
        end
    endtask

    task automatic run_vector(input int idx);
        logic [`LDPC_CRC_BITS-1:0] crc;
        logic                      dat;
        logic [31:0]               rnd_word;
        ldpc_pkg::message_t        msg;
        ldpc_pkg::codeword_t       held;
        int                        edges;
        int                        errs_before;
        errs_before = err_count;
        crc = stim_table[idx].crc;
        dat = stim_table[idx].data;
        if (stim_table[idx].rnd) begin
            rnd_word = $urandom;
            crc = rnd_word[15:0];
            dat = rnd_word[16];
        end
        msg = model_message(crc, dat);

        @(negedge CLK);
        req      = 1'b1;
        crc_bits = crc;
        data_bit = dat;
        edges    = 0;
        while (ack !== 1'b1 && edges < ACK_LIMIT) begin
            @(posedge CLK);
            edges++;
            @(negedge CLK);
            check_ack("ack", ack, edges >= ACK_LATENCY);
        end
        if (ack !== 1'b1) begin
            err_count++;
            $display("ack did not rise within %0d cycles of req, test %0d", ACK_LIMIT, idx + 1);
        end else begin
            check_codeword("codeword", codeword, model_codeword(msg));
            check_codeword("codeword[15:0]", ldpc_pkg::codeword_t'(codeword[15:0]),
                ldpc_pkg::codeword_t'(msg[`LDPC_MSG_BITS-1:2*`LDPC_ZC]));
            if (!stim_table[idx].rnd && crc == '0 && !dat) begin
                check_codeword("codeword zero message", codeword, '0);
            end
            held     = codeword;
            crc_bits = ~crc;   // inputs free once ack is seen
            data_bit = ~dat;
            for (int h = 0; h < idx % 3; h++) begin
                @(posedge CLK);
                @(negedge CLK);
                check_ack("ack hold", ack, 1'b1);
                check_codeword("codeword hold", codeword, held);
            end
        end
        req = 1'b0;
        @(posedge CLK);
        @(negedge CLK);
        check_ack("ack after req low", ack, 1'b0);
        if (err_count == errs_before) begin
            check_codeword("codeword after release", codeword, held);
        end
        if (err_count == errs_before) begin
            $display("test %0d crc=%h data=%b: ok", idx + 1, crc, dat);
        end else begin
            fail_tests++;
            $display("test %0d crc=%h data=%b: %0d errors", idx + 1, crc, dat,
                err_count - errs_before);
        end
    endtask

    initial begin
        CLK        = 1'b0;
        RST        = 1'b0;
        req        = 1'b0;
        crc_bits   = '0;
        data_bit   = 1'b0;
        err_count  = 0;
        fail_tests = 0;
        void'($urandom(18));
        fill_table();

        repeat (4) @(posedge CLK);
        @(negedge CLK);
        check_ack("ack in reset", ack, 1'b0);
        check_codeword("codeword in reset", codeword, '0);
        RST = 1'b1;
        @(negedge CLK);
        check_ack("ack after reset", ack, 1'b0);
        check_codeword("codeword after reset", codeword, '0);
        if (err_count == 0) begin
            $display("test 0 reset: ok");
        end else begin
            fail_tests++;
            $display("test 0 reset: %0d errors", err_count);
        end

        for (int i = 0; i < NUM_VECTORS; i++) begin
            run_vector(i);
        end

        $display("tests run: %0d, tests failed: %0d, errors: %0d",
            NUM_VECTORS + 1, fail_tests, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/handshake_ctrl.sv */
`timescale 1ns/1ns
`include "ldpc_macros.svh"
`default_nettype none

module handshake_ctrl (
    input  logic                      CLK,
    input  logic                      RST,
    input  logic                      req,
    input  logic [`LDPC_CRC_BITS-1:0] crc_bits,
    input  logic                      data_bit,
    output logic                      ack,
    output ldpc_pkg::message_t        message,
    output logic                      core_load,
    output logic                      ext_load
);

    ldpc_pkg::enc_state_e state;
    ldpc_pkg::enc_state_e state_next;
    logic                 accept;

    assign accept = (state == ldpc_pkg::IDLE) && req;

    always_comb begin
        state_next = state;
        case (state)
            ldpc_pkg::IDLE: begin
                if (req) begin
                    state_next = ldpc_pkg::CORE;
                end
            end
            ldpc_pkg::CORE: state_next = ldpc_pkg::EXT;
            ldpc_pkg::EXT:  state_next = ldpc_pkg::DONE;
            ldpc_pkg::DONE: begin
                // wait for requester to drop req
                if (!req) begin
                    state_next = ldpc_pkg::IDLE;
                end
            end
            default: state_next = ldpc_pkg::IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            state <= ldpc_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // zero-extend crc and data bit into the 20 bit word
    always_ff @(posedge CLK) begin
        if (accept) begin
            message <= ldpc_pkg::message_t'({crc_bits, data_bit});
        end
    end

    assign core_load = (state == ldpc_pkg::CORE);   // one cycle after capture
    assign ext_load  = (state == ldpc_pkg::EXT);
    assign ack       = (state == ldpc_pkg::DONE);

    // message must not move while the codeword is presented
    a_ack_msg_stable: assert property (@(posedge CLK) disable iff (!RST)
        ack |-> $stable(message));

    // stage enables never overlapping
    a_load_order: assert property (@(posedge CLK) disable iff (!RST)
        !(core_load && ext_load));

endmodule

`default_nettype wire

/* verilog/ldpc_encoder.sv */
`timescale 1ns/1ns
`include "ldpc_macros.svh"
`default_nettype none

module ldpc_encoder (
    input  logic                      CLK,
    input  logic                      RST,
    input  logic                      req,
    input  logic [`LDPC_CRC_BITS-1:0] crc_bits,
    input  logic                      data_bit,
    output logic                      ack,
    output ldpc_pkg::codeword_t       codeword
);

    ldpc_pkg::message_t message;   // held from capture until the next request
    logic               core_load;
    logic               ext_load;
    ldpc_pkg::block_t   pa_blocks [`LDPC_CORE_ROWS];

    // req/ack sequencing and message capture
    handshake_ctrl u_handshake_ctrl (
        .CLK       (CLK),
        .RST       (RST),
        .req       (req),
        .crc_bits  (crc_bits),
        .data_bit  (data_bit),
        .ack       (ack),
        .message   (message),
        .core_load (core_load),
        .ext_load  (ext_load)
    );

    // lambda sums and double-diagonal solve
    core_parity u_core_parity (
        .CLK       (CLK),
        .RST       (RST),
        .message   (message),
        .core_load (core_load),
        .pa_blocks (pa_blocks)
    );

    ext_parity u_ext_parity (
        .CLK       (CLK),
        .RST       (RST),
        .message   (message),
        .pa_blocks (pa_blocks),
        .ext_load  (ext_load),
        .codeword  (codeword)    // registered output
    );

endmodule

`default_nettype wire
